// File: logic/fpu_op_pkg.sv
package fpu_op_pkg;

  // single-precision operations that need no rounding
  typedef enum logic [3:0] {
    OP_FSGNJ  = 4'd0,
    OP_FSGNJN = 4'd1,
    OP_FSGNJX = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FEQ    = 4'd5,
    OP_FLT    = 4'd6,
    OP_FLE    = 4'd7,
    OP_FCLASS = 4'd8
  } fpu_op_e;

  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;  // canonical quiet nan

  // bit positions of the fclass one-hot mask
  localparam int unsigned CLS_NEG_INF  = 0;
  localparam int unsigned CLS_NEG_NORM = 1;
  localparam int unsigned CLS_NEG_SUB  = 2;
  localparam int unsigned CLS_NEG_ZERO = 3;
  localparam int unsigned CLS_POS_ZERO = 4;
  localparam int unsigned CLS_POS_SUB  = 5;
  localparam int unsigned CLS_POS_NORM = 6;
  localparam int unsigned CLS_POS_INF  = 7;
  localparam int unsigned CLS_SNAN     = 8;
  localparam int unsigned CLS_QNAN     = 9;

  // first stage, operation as issued
  typedef struct packed {
    fpu_op_e     op;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } issue_t;

  // second stage, finished result
  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  fflags;  // nv nz of uf nx
  } result_t;

endpackage

// File: logic/fpu_csr_pkg.sv
package fpu_csr_pkg;

  // register offsets, low 4 address bits
  localparam logic [3:0] ADDR_CTRL     = 4'h0;
  localparam logic [3:0] ADDR_FFLAGS   = 4'h4;
  localparam logic [3:0] ADDR_IRQ_MASK = 4'h8;
  localparam logic [3:0] ADDR_OP_COUNT = 4'hc;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // fflags layout follows the riscv fcsr
  localparam int unsigned FLAG_NV = 4;  // invalid operation

  // ctrl register bits
  localparam int unsigned CTRL_ENABLE = 0;
  localparam int unsigned CTRL_BUSY   = 1;  // read only

endpackage

// File: logic/fpu_status_if.sv
`timescale 1ns/100ps

interface fpu_status_if;

  logic       enable;        // operand port open
  logic       accrue_valid;  // one pulse per result transfer
  logic [4:0] accrue_flags;
  logic       busy;          // items in flight

  modport regs (
    output enable,
    input  accrue_valid,
    input  accrue_flags,
    input  busy
  );

  modport datapath (
    input  enable,
    output accrue_valid,
    output accrue_flags,
    output busy
  );

endinterface

// File: logic/fpu_pipe_stage.sv
`timescale 1ns/100ps

module fpu_pipe_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     i_clk,
  input  logic     arst_n,

  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,

  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  logic     valid_q;
  payload_t data_q;

  // free slot, or the held item leaves this cycle
  assign up_ready = ~valid_q | dn_ready;

  always_ff @(posedge i_clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (up_ready) begin
      valid_q <= up_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (up_valid && up_ready) begin
      data_q <= up_data;
    end
  end

  assign dn_valid = valid_q;
  assign dn_data  = data_q;

endmodule

// File: logic/fpu_nonarith_unit.sv
`timescale 1ns/100ps

module fpu_nonarith_unit
  import fpu_op_pkg::*;
  import fpu_csr_pkg::*;
(
  input  logic           i_clk,
  input  logic           arst_n,

  input  logic           in_valid,
  output logic           in_ready,
  input  fpu_op_e        in_op,
  input  logic [31:0]    in_rs1,
  input  logic [31:0]    in_rs2,

  output logic           out_valid,
  input  logic           out_ready,
  output logic [31:0]    out_result,
  output logic [4:0]     out_fflags,

  fpu_status_if.datapath status
);

  issue_t      issue_in;
  issue_t      issue_q;
  logic        issue_up_valid;
  logic        issue_up_ready;
  logic        issue_valid;
  logic        issue_ready;
  result_t     result_d;
  result_t     result_q;

  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [9:0]  cls1;
  logic [9:0]  cls2;
  logic        nan1;
  logic        nan2;
  logic        nan_any;
  logic        snan_any;
  logic        both_zero;
  logic        lt_ord;  // total order, -0 below +0
  logic        flt;
  logic        feq;

  function automatic logic [9:0] fp_class(input logic [31:0] x);
    logic        sgn;
    logic [7:0]  ex;
    logic [22:0] man;
    logic [9:0]  m;
    sgn = x[31];
    ex  = x[30:23];
    man = x[22:0];
    m   = '0;
    if (ex == 8'hff) begin
      if (man == '0) m[sgn ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
      else if (man[22]) m[CLS_QNAN] = 1'b1;  // quiet bit set
      else m[CLS_SNAN] = 1'b1;
    end else if (ex == '0) begin
      if (man == '0) m[sgn ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
      else m[sgn ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
    end else begin
      m[sgn ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
    end
    return m;
  endfunction

  // operand port closes while disabled
  assign issue_up_valid = in_valid & status.enable;
  assign in_ready       = issue_up_ready & status.enable;

  assign issue_in.op  = in_op;
  assign issue_in.rs1 = in_rs1;
  assign issue_in.rs2 = in_rs2;

  fpu_pipe_stage #(.payload_t(issue_t)) issue_stage (
    .i_clk    (i_clk),
    .arst_n   (arst_n),
    .up_valid (issue_up_valid),
    .up_ready (issue_up_ready),
    .up_data  (issue_in),
    .dn_valid (issue_valid),
    .dn_ready (issue_ready),
    .dn_data  (issue_q)
  );

  assign rs1  = issue_q.rs1;
  assign rs2  = issue_q.rs2;
  assign cls1 = fp_class(rs1);
  assign cls2 = fp_class(rs2);

  assign nan1      = cls1[CLS_SNAN] | cls1[CLS_QNAN];
  assign nan2      = cls2[CLS_SNAN] | cls2[CLS_QNAN];
  assign nan_any   = nan1 | nan2;
  assign snan_any  = cls1[CLS_SNAN] | cls2[CLS_SNAN];
  assign both_zero = (rs1[30:0] == '0) && (rs2[30:0] == '0);

  assign lt_ord = (rs1[31] != rs2[31]) ? rs1[31] :
                  rs1[31] ? (rs1[30:0] > rs2[30:0]) : (rs1[30:0] < rs2[30:0]);
  assign flt    = lt_ord & ~both_zero;  // compares treat the zeros as equal
  assign feq    = (rs1 == rs2) | both_zero;

  always_comb begin
    result_d.result = '0;
    result_d.fflags = '0;
    case (issue_q.op)
      OP_FSGNJ:  result_d.result = {rs2[31], rs1[30:0]};
      OP_FSGNJN: result_d.result = {~rs2[31], rs1[30:0]};
      OP_FSGNJX: result_d.result = {rs1[31] ^ rs2[31], rs1[30:0]};
      OP_FMIN, OP_FMAX: begin
        if (nan1 && nan2) result_d.result = CANON_NAN;
        else if (nan1) result_d.result = rs2;
        else if (nan2) result_d.result = rs1;
        else if (lt_ord ^ (issue_q.op == OP_FMAX)) result_d.result = rs1;
        else result_d.result = rs2;
        result_d.fflags[FLAG_NV] = snan_any;
      end
      OP_FEQ: begin
        result_d.result          = {31'b0, feq & ~nan_any};
        result_d.fflags[FLAG_NV] = snan_any;  // quiet compare
      end
      OP_FLT: begin
        result_d.result          = {31'b0, flt & ~nan_any};
        result_d.fflags[FLAG_NV] = nan_any;   // signaling compare
      end
      OP_FLE: begin
        result_d.result          = {31'b0, (flt | feq) & ~nan_any};
        result_d.fflags[FLAG_NV] = nan_any;
      end
      OP_FCLASS: result_d.result = {22'b0, cls1};
      default:   result_d.fflags[FLAG_NV] = 1'b1;  // illegal code
    endcase
  end

  fpu_pipe_stage #(.payload_t(result_t)) result_stage (
    .i_clk    (i_clk),
    .arst_n   (arst_n),
    .up_valid (issue_valid),
    .up_ready (issue_ready),
    .up_data  (result_d),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (result_q)
  );

  assign out_result = result_q.result;
  assign out_fflags = result_q.fflags;

  assign status.accrue_valid = out_valid & out_ready;
  assign status.accrue_flags = result_q.fflags;
  assign status.busy         = issue_valid | out_valid;

endmodule

// File: logic/fpu_csr_regs.sv
`timescale 1ns/100ps

module fpu_csr_regs
  import fpu_csr_pkg::*;
#(
  parameter int AXI_ADDR_W = 4,
  parameter int COUNT_W    = 16
) (
  input  logic                  i_clk,
  input  logic                  arst_n,

  input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  input  logic [31:0]           s_axi_wdata,
  input  logic [3:0]            s_axi_wstrb,
  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  output logic [1:0]            s_axi_bresp,
  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,

  input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  output logic [31:0]           s_axi_rdata,
  output logic [1:0]            s_axi_rresp,
  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready,

  fpu_status_if.regs            status,
  output logic                  irq
);

  logic [3:0]         wr_off;
  logic [3:0]         rd_off;
  logic               wr_fire;
  logic               rd_fire;
  logic               wr_en;
  logic               enable_q;
  logic [4:0]         fflags_q;
  logic [4:0]         fflags_d;
  logic [4:0]         clr_mask;
  logic [4:0]         mask_q;
  logic [4:0]         mask_d;
  logic [COUNT_W-1:0] count_q;
  logic [31:0]        rd_data;

  function automatic logic is_mapped(input logic [3:0] off);
    return (off == ADDR_CTRL) || (off == ADDR_FFLAGS) ||
           (off == ADDR_IRQ_MASK) || (off == ADDR_OP_COUNT);
  endfunction

  assign wr_off  = s_axi_awaddr[3:0];  // wider buses alias every 16 bytes
  assign rd_off  = s_axi_araddr[3:0];
  assign wr_fire = s_axi_awvalid & s_axi_awready & s_axi_wvalid & s_axi_wready;
  assign rd_fire = s_axi_arvalid & s_axi_arready;
  assign wr_en   = wr_fire & s_axi_wstrb[0];  // all fields sit in byte 0

  // w1c clear, accrue wins on a collision
  assign clr_mask = (wr_en && wr_off == ADDR_FFLAGS) ? s_axi_wdata[4:0] : 5'b0;
  assign fflags_d = (fflags_q & ~clr_mask) |
                    (status.accrue_valid ? status.accrue_flags : 5'b0);
  assign mask_d   = (wr_en && wr_off == ADDR_IRQ_MASK) ? s_axi_wdata[4:0] : mask_q;

  always_ff @(posedge i_clk or negedge arst_n) begin
    if (!arst_n) begin
      enable_q <= 1'b0;
      fflags_q <= '0;
      mask_q   <= '0;
      count_q  <= '0;
      irq      <= 1'b0;
    end else begin
      if (wr_en && wr_off == ADDR_CTRL) enable_q <= s_axi_wdata[CTRL_ENABLE];
      fflags_q <= fflags_d;
      mask_q   <= mask_d;
      count_q  <= count_q + COUNT_W'(status.accrue_valid);  // wraps
      irq      <= |(fflags_d & mask_d);  // follows the new register values
    end
  end

  assign status.enable = enable_q;

  // write channel, address and data taken together
  always_ff @(posedge i_clk or negedge arst_n) begin
    if (!arst_n) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= RESP_OKAY;
    end else begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      if (!s_axi_awready && !s_axi_bvalid && s_axi_awvalid && s_axi_wvalid) begin
        s_axi_awready <= 1'b1;
        s_axi_wready  <= 1'b1;
      end
      if (wr_fire) begin
        s_axi_bvalid <= 1'b1;
        s_axi_bresp  <= is_mapped(wr_off) ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (rd_off)
      ADDR_CTRL: begin
        rd_data[CTRL_ENABLE] = enable_q;
        rd_data[CTRL_BUSY]   = status.busy;
      end
      ADDR_FFLAGS:   rd_data[4:0] = fflags_q;
      ADDR_IRQ_MASK: rd_data[4:0] = mask_q;
      ADDR_OP_COUNT: rd_data      = 32'(count_q);
      default:       rd_data      = '0;  // unmapped reads as zero
    endcase
  end

  // read channel
  always_ff @(posedge i_clk or negedge arst_n) begin
    if (!arst_n) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= RESP_OKAY;
      s_axi_rdata   <= '0;
    end else begin
      s_axi_arready <= 1'b0;
      if (!s_axi_arready && !s_axi_rvalid && s_axi_arvalid) begin
        s_axi_arready <= 1'b1;
      end
      if (rd_fire) begin
        s_axi_rvalid <= 1'b1;
        s_axi_rdata  <= rd_data;
        s_axi_rresp  <= is_mapped(rd_off) ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

endmodule

// File: logic/fpu_top.sv
`timescale 1ns/100ps

module fpu_top
  import fpu_op_pkg::*;
#(
  parameter int AXI_ADDR_W = 4,
  parameter int COUNT_W    = 16
) (
  input  logic                  i_clk,
  input  logic                  arst_n,

  // operand port
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fpu_op_e               in_op,
  input  logic [31:0]           in_rs1,
  input  logic [31:0]           in_rs2,

  // result port
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [31:0]           out_result,
  output logic [4:0]            out_fflags,

  // axi4-lite register port
  input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  input  logic [31:0]           s_axi_wdata,
  input  logic [3:0]            s_axi_wstrb,
  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  output logic [1:0]            s_axi_bresp,
  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,
  input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  output logic [31:0]           s_axi_rdata,
  output logic [1:0]            s_axi_rresp,
  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready,

  output logic                  irq
);

  fpu_status_if status_if ();

  fpu_nonarith_unit nonarith_inst (
    .i_clk      (i_clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_rs1     (in_rs1),
    .in_rs2     (in_rs2),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_fflags (out_fflags),
    .status     (status_if.datapath)
  );

  fpu_csr_regs #(
    .AXI_ADDR_W (AXI_ADDR_W),
    .COUNT_W    (COUNT_W)
  ) csr_inst (
    .i_clk         (i_clk),
    .arst_n        (arst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .status        (status_if.regs),
    .irq           (irq)
  );

endmodule

// File: dv/fpu_props.sv
`timescale 1ns/100ps

module fpu_props (
  input logic        i_clk,
  input logic        arst_n,
  input logic        in_valid,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] out_result,
  input logic [4:0]  out_fflags,
  input logic [4:0]  fflags,
  input logic [4:0]  irq_mask,
  input logic        irq
);

  bit   latency_bad = 1'b0;
  bit   hold_bad    = 1'b0;
  bit   irq_bad     = 1'b0;
  logic failed;  // watched by the testbench

  assign failed = latency_bad | hold_bad | irq_bad;

  // two stages, no stall while the consumer keeps up
  latency_a: assert property (@(posedge i_clk) disable iff (!arst_n)
    (in_valid && in_ready) ##1 out_ready |=> out_valid)
  else begin
    latency_bad = 1'b1;
    $error("result not valid two cycles after its input transfer");
  end

  hold_a: assert property (@(posedge i_clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> out_valid && $stable(out_result) && $stable(out_fflags))
  else begin
    hold_bad = 1'b1;
    $error("result port changed while stalled");
  end

  irq_a: assert property (@(posedge i_clk) disable iff (!arst_n)
    irq |-> |(fflags & irq_mask))
  else begin
    irq_bad = 1'b1;
    $error("irq high with no unmasked flag");
  end

endmodule

bind fpu_top fpu_props props_inst (
  .i_clk      (i_clk),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_result (out_result),
  .out_fflags (out_fflags),
  .fflags     (csr_inst.fflags_q),
  .irq_mask   (csr_inst.mask_q),
  .irq        (irq)
);

// File: dv/fpu_tb.sv
`timescale 1ns/100ps

module fpu_tb
  import fpu_op_pkg::*;
  import fpu_csr_pkg::*;
();

  localparam int N_OPS      = 300;
  localparam int COUNT_W    = 16;
  localparam int AXI_PHASES = 30;  // register accesses over all tests
  localparam int WATCHDOG_CYCLES = 10 + (2 * N_OPS + 8) * 20 + AXI_PHASES * 20;

  logic        i_clk;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  fpu_op_e     in_op;
  logic [31:0] in_rs1;
  logic [31:0] in_rs2;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] out_result;
  logic [4:0]  out_fflags;
  logic [3:0]  s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  logic [3:0]  s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        irq;

  logic [36:0] exp_q[$];  // {fflags, result}
  int          issued    = 0;
  int          done_cnt  = 0;
  logic [4:0]  acc_flags = 5'b0;  // model flags of all results
  logic        bp_on     = 1'b0;
  string       test_name = "reset_enable";

  fpu_top #(
    .AXI_ADDR_W (4),
    .COUNT_W    (COUNT_W)
  ) fpu_top_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    fail_run($sformatf("mismatch in %s, %s: expected %h actual %h",
                       test_name, what, exp, act));
  endtask

  // one-hot class, riscv bit order
  function automatic logic [9:0] class_mask(input logic [31:0] x);
    logic exp_max;
    logic exp_zero;
    logic frac_zero;
    exp_max   = &x[30:23];
    exp_zero  = ~|x[30:23];
    frac_zero = ~|x[22:0];
    if (exp_max && !frac_zero) return x[22] ? 10'h200 : 10'h100;
    if (exp_max) return x[31] ? 10'h001 : 10'h080;
    if (exp_zero && frac_zero) return x[31] ? 10'h008 : 10'h010;
    if (exp_zero) return x[31] ? 10'h004 : 10'h020;
    return x[31] ? 10'h002 : 10'h040;
  endfunction

  // unsigned key in numeric order, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [36:0] model_op(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic        a_nan;
    logic        b_nan;
    logic        any_snan;
    logic        zeros;
    logic        a_lt;
    logic        a_eq;
    logic        nv;
    logic [31:0] res;
    a_nan    = |(class_mask(a) & 10'h300);
    b_nan    = |(class_mask(b) & 10'h300);
    any_snan = |((class_mask(a) | class_mask(b)) & 10'h100);
    zeros    = (a[30:0] == '0) && (b[30:0] == '0);
    a_lt     = order_key(a) < order_key(b);
    a_eq     = (a == b) || zeros;
    res      = '0;
    nv       = 1'b0;
    case (op)
      OP_FSGNJ:  res = {b[31], a[30:0]};
      OP_FSGNJN: res = {~b[31], a[30:0]};
      OP_FSGNJX: res = {a[31] ^ b[31], a[30:0]};
      OP_FMIN: begin
        res = (a_nan && b_nan) ? CANON_NAN : a_nan ? b : b_nan ? a : a_lt ? a : b;
        nv  = any_snan;
      end
      OP_FMAX: begin
        res = (a_nan && b_nan) ? CANON_NAN : a_nan ? b : b_nan ? a : a_lt ? b : a;
        nv  = any_snan;
      end
      OP_FEQ: begin
        res = {31'b0, a_eq && !(a_nan || b_nan)};
        nv  = any_snan;
      end
      OP_FLT: begin
        res = {31'b0, a_lt && !zeros && !(a_nan || b_nan)};
        nv  = a_nan || b_nan;
      end
      OP_FLE: begin
        res = {31'b0, (a_lt || a_eq) && !(a_nan || b_nan)};
        nv  = a_nan || b_nan;
      end
      OP_FCLASS: res = {22'b0, class_mask(a)};
      default:   nv = 1'b1;  // illegal code
    endcase
    return {nv, 4'b0, res};
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $urandom;
    case ($urandom % 8)
      0: return {r[31], 31'b0};
      1: return {r[31], 8'hff, 23'b0};  // infinity
      2: return {r[31], 8'hff, 1'b1, r[21:0]};  // quiet nan
      3: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};  // signaling nan
      4: return {r[31], 8'h00, r[22:1], 1'b1};  // subnormal
      5: return {r[31], 8'h3f, r[22:0]};  // close values
      default: return r;
    endcase
  endfunction

  task automatic send_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b);
    @(negedge i_clk);
    in_valid = 1'b1;
    in_op    = fpu_op_e'(code);
    in_rs1   = a;
    in_rs2   = b;
    #2;
    while (!in_ready) begin
      @(negedge i_clk);
      #2;
    end
    exp_q.push_back(model_op(code, a, b));
    issued++;
  endtask

  task automatic finish_ops();
    @(negedge i_clk);
    in_valid = 1'b0;
    while (done_cnt != issued) @(negedge i_clk);
  endtask

  task automatic run_random(input int n);
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      a = pick_operand();
      send_op(4'($urandom % 9), a, ($urandom % 5 == 0) ? a : pick_operand());
    end
    finish_ops();
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge i_clk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    #2;
    while (!(s_axi_awready && s_axi_wready)) begin
      @(negedge i_clk);
      #2;
    end
    @(negedge i_clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    #2;
    while (!s_axi_bvalid) begin
      @(negedge i_clk);
      #2;
    end
    resp = s_axi_bresp;  // bready held high
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge i_clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    #2;
    while (!s_axi_arready) begin
      @(negedge i_clk);
      #2;
    end
    @(negedge i_clk);
    s_axi_arvalid = 1'b0;
    #2;
    while (!s_axi_rvalid) begin
      @(negedge i_clk);
      #2;
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    assert (resp == RESP_OKAY) else report_mismatch("write response", 32'(RESP_OKAY), 32'(resp));
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    assert (resp == RESP_OKAY) else report_mismatch("read response", 32'(RESP_OKAY), 32'(resp));
    assert (data == exp) else report_mismatch($sformatf("register %h", addr), exp, data);
  endtask

  // consumer side, random stalls when enabled
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge i_clk);
      out_ready = bp_on ? 1'($urandom % 2) : 1'b1;
    end
  end

  initial begin : scoreboard
    logic [36:0] exp;
    forever begin
      @(negedge i_clk);
      #2;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) fail_run("result came out with no operation outstanding");
        else begin
          exp = exp_q.pop_front();
          assert (out_result == exp[31:0]) else report_mismatch("result", exp[31:0], out_result);
          assert (out_fflags == exp[36:32])
            else report_mismatch("fflags", {27'b0, exp[36:32]}, {27'b0, out_fflags});
          acc_flags = acc_flags | exp[36:32];
          done_cnt++;
        end
      end
    end
  end

  initial begin
    forever begin
      @(negedge i_clk);
      if (fpu_top_inst.props_inst.failed) fail_run("an assertion in fpu_props failed");
    end
  end

  // ops times 20 cycles plus the register accesses
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin : main
    logic [31:0] rdata;
    logic [1:0]  resp;
    void'($urandom(60));
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_op         = OP_FSGNJ;
    in_rs1        = '0;
    in_rs2        = '0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = 4'hf;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    arst_n = 1'b1;

    repeat (4) begin
      @(negedge i_clk);
      #2;
      assert (!in_ready && !out_valid && !irq)
        else fail_run("operand port open or outputs active before enable");
    end
    check_reg(ADDR_CTRL, 32'h0);
    check_reg(ADDR_FFLAGS, 32'h0);
    check_reg(ADDR_IRQ_MASK, 32'h0);
    check_reg(ADDR_OP_COUNT, 32'h0);
    write_reg(ADDR_CTRL, 32'h1);
    check_reg(ADDR_CTRL, 32'h1);
    @(negedge i_clk);
    #2;
    assert (in_ready) else fail_run("in_ready stayed low after enable");

    test_name = "random_flow";
    run_random(N_OPS);

    test_name = "random_backpressure";
    bp_on = 1'b1;
    run_random(N_OPS);
    bp_on = 1'b0;

    test_name = "flag_count";
    assert (acc_flags[FLAG_NV]) else fail_run("random operations never raised the invalid flag");
    check_reg(ADDR_FFLAGS, {27'b0, acc_flags});
    check_reg(ADDR_OP_COUNT, 32'(done_cnt % (1 << COUNT_W)));
    write_reg(ADDR_FFLAGS, 32'h1f);
    check_reg(ADDR_FFLAGS, 32'h0);

    test_name = "irq";
    write_reg(ADDR_IRQ_MASK, 32'h1 << FLAG_NV);
    assert (!irq) else fail_run("irq high with all flags clear");
    send_op(OP_FEQ, 32'h7f80_0001, 32'h0);  // snan compare
    finish_ops();
    #2;
    assert (irq) else fail_run("irq stayed low after a signaling nan compare");
    write_reg(ADDR_FFLAGS, 32'h1 << FLAG_NV);
    assert (!irq) else fail_run("irq stayed high after the flags were cleared");

    test_name = "unmapped_illegal";
    axi_write(4'he, 32'hffff_ffff, resp);
    assert (resp == RESP_SLVERR)
      else report_mismatch("write response", 32'(RESP_SLVERR), 32'(resp));
    axi_read(4'he, rdata, resp);
    assert (resp == RESP_SLVERR)
      else report_mismatch("read response", 32'(RESP_SLVERR), 32'(resp));
    assert (rdata == 32'h0) else report_mismatch("unmapped read data", 32'h0, rdata);
    check_reg(ADDR_CTRL, 32'h1);  // still enabled, pipeline idle
    check_reg(ADDR_FFLAGS, 32'h0);
    check_reg(ADDR_IRQ_MASK, 32'h1 << FLAG_NV);
    check_reg(ADDR_OP_COUNT, 32'(done_cnt % (1 << COUNT_W)));
    send_op(4'hb, $urandom, $urandom);  // no such operation
    finish_ops();
    check_reg(ADDR_FFLAGS, 32'h1 << FLAG_NV);

    if (fpu_top_inst.props_inst.failed) fail_run("an assertion in fpu_props failed");
    else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: all.f
logic/fpu_op_pkg.sv
logic/fpu_csr_pkg.sv
logic/fpu_status_if.sv
logic/fpu_pipe_stage.sv
logic/fpu_nonarith_unit.sv
logic/fpu_csr_regs.sv
logic/fpu_top.sv
dv/fpu_props.sv
dv/fpu_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fpu_tb -Mdir obj_dir -f all.f || exit 1
out=$(./obj_dir/Vfpu_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
